//--- pet_core.f
hw/common_pkg.sv
hw/cycle_counter.sv
hw/address_decoder.sv
hw/bus_timing.sv
hw/spi_target.sv
hw/pet_core.sv
tests/mock_ram.sv
tests/tb_pet_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pet_core -f pet_core.f \
    --Mdir obj_dir -o tb_pet_core_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/tb_pet_core_sim)"
echo "$sim_output"
echo "$sim_output" | grep -q "Verification passed" && exit 0 || exit 1

//--- tests/tb_pet_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pet_core;

    localparam int CYCLE_LEN  = 8;
    localparam int SCK_HALF   = 4;
    localparam int WAIT_LIMIT = 400;

    logic        sys_clock, reset, cpu_we_n, spi_cs_n, spi_sck, spi_sdi;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data, ram_data, bus_data;
    logic [16:0] ram_addr;
    logic        cpu_clock, cpu_be, cpu_ready, ram_oe_n, ram_we_n, bus_data_oe, bus_addr_oe;
    logic        io_oe_n, pia1_cs_n, pia2_cs_n, via_cs_n, spi_sdo, spi_stall;

    int          errors;
    bit          timed_out;
    bit          ready_seen;
    logic [7:0]  mem_model [logic [16:0]];

    initial begin
        sys_clock = 1'b0;
        forever #10 sys_clock = ~sys_clock;
    end

    pet_core #(.CYCLE_LEN(CYCLE_LEN)) dut (
        .sys_clock_i(sys_clock), .reset_i(reset),
        .cpu_addr_i(cpu_addr), .cpu_data_i(cpu_data), .cpu_we_n_i(cpu_we_n),
        .ram_data_i(ram_data), .spi_cs_ni(spi_cs_n), .spi_sck_i(spi_sck), .spi_sd_i(spi_sdi),
        .cpu_clock_o(cpu_clock), .cpu_be_o(cpu_be), .cpu_ready_o(cpu_ready),
        .ram_addr_o(ram_addr), .ram_oe_n_o(ram_oe_n), .ram_we_n_o(ram_we_n),
        .bus_data_o(bus_data), .bus_data_oe_o(bus_data_oe), .bus_addr_oe_o(bus_addr_oe),
        .io_oe_n_o(io_oe_n), .pia1_cs_n_o(pia1_cs_n), .pia2_cs_n_o(pia2_cs_n),
        .via_cs_n_o(via_cs_n), .spi_sd_o(spi_sdo), .spi_stall_o(spi_stall)
    );

    mock_ram ram (
        .addr_i(ram_addr), .data_i(bus_data), .oe_n_i(ram_oe_n), .we_n_i(ram_we_n),
        .data_o(ram_data)
    );

    // PET memory map: I/O page E800-EFFF, ROM B000-E7FF and F000-FFFF
    function automatic common_pkg::chip_sel_t decode_ref(input logic [15:0] addr);
        common_pkg::chip_sel_t sel;
        logic                  io;
        io              = (addr >= 16'hE800) && (addr <= 16'hEFFF);
        sel.ram_en      = !io;
        sel.io_sel      = io;
        sel.rom_protect = (addr >= 16'hB000 && addr < 16'hE800) || (addr >= 16'hF000);
        sel.pia1        = io && addr[4];
        sel.pia2        = io && addr[5];
        sel.via         = io && addr[6];
        return sel;
    endfunction

    function automatic logic [7:0] model_read(input logic [16:0] addr);
        return mem_model.exists(addr) ? mem_model[addr] : 8'hxx;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timed out at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge sys_clock);
        #1;
    endtask

    task automatic check_idle_outputs();
        logic [11:0] got;
        got = {cpu_clock, cpu_be, cpu_ready, ram_oe_n, ram_we_n, pia1_cs_n, pia2_cs_n,
               via_cs_n, io_oe_n, spi_stall, bus_data_oe, bus_addr_oe};
        if (got !== 12'h1F8) report_mismatch("cpu_clock_o..bus_addr_oe_o", 32'(got), 32'h1F8);
    endtask

    // Compares the CPU slot outputs against the decode model
    always @(negedge sys_clock) begin
        common_pkg::chip_sel_t sel;
        logic [5:0]            got;
        logic [5:0]            exp;
        sel = decode_ref(cpu_addr);
        got = {cpu_be, pia1_cs_n, pia2_cs_n, via_cs_n, io_oe_n, ram_oe_n};
        exp = {1'b1, !sel.pia1, !sel.pia2, !sel.via, !(cpu_we_n && sel.io_sel),
               !(cpu_we_n && sel.ram_en)};
        if (cpu_clock === 1'b1) begin
            if (got !== exp) begin
                report_mismatch("cpu_be_o,cs_n,io_oe_n_o,ram_oe_n_o", 32'(got), 32'(exp));
            end
            if (ram_addr !== {1'b0, cpu_addr}) begin
                report_mismatch("ram_addr_o", 32'(ram_addr), 32'(cpu_addr));
            end
            if ({bus_data_oe, bus_addr_oe} !== 2'b00) begin
                report_mismatch("bus_data_oe_o,bus_addr_oe_o",
                                32'({bus_data_oe, bus_addr_oe}), 0);
            end
        end
        if (ready_seen && cpu_ready !== 1'b1) report_mismatch("cpu_ready_o", 32'(cpu_ready), 1);
    end

    task automatic wait_cpu_clock(input logic level);
        int n;
        n = 0;
        while (cpu_clock !== level && n < WAIT_LIMIT && !timed_out) begin
            tick(1);
            n++;
        end
        if (cpu_clock !== level && !timed_out) report_timeout("a cpu_clock_o edge");
    endtask

    task automatic cpu_cycle(input logic [15:0] addr, input logic we, input logic [7:0] wdata,
                             output logic [7:0] rdata);
        common_pkg::chip_sel_t sel;
        int                    n;
        sel   = decode_ref(addr);
        rdata = 8'hxx;
        n     = 0;
        wait_cpu_clock(1'b0);
        wait_cpu_clock(1'b1);
        if (timed_out) return;
        cpu_addr = addr;
        cpu_data = wdata;
        cpu_we_n = !we;
        // Last sample before cpu_clock_o falls is the read result
        while (cpu_clock === 1'b1 && n < WAIT_LIMIT) begin
            tick(1);
            n++;
            if (cpu_clock === 1'b1) rdata = io_oe_n ? ram_data : 8'h10;
        end
        if (cpu_clock === 1'b1) report_timeout("the end of a CPU slot");
        cpu_we_n = 1'b1;
        if (we && sel.ram_en && !sel.rom_protect) mem_model[{1'b0, addr}] = wdata;
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        cpu_cycle(addr, 1'b1, data, unused);
    endtask

    task automatic expect_cpu_read(input logic [15:0] addr);
        common_pkg::chip_sel_t sel;
        logic [7:0]            got;
        sel = decode_ref(addr);
        cpu_cycle(addr, 1'b0, 8'h00, got);
        if (timed_out) return;
        if (sel.io_sel) begin
            if (got !== 8'h10) report_mismatch("cpu read data", 32'(got), 32'h10);
        end else if (mem_model.exists({1'b0, addr})) begin
            if (got !== model_read({1'b0, addr})) report_mismatch("cpu read data", 32'(got),
                                                                  32'(model_read({1'b0, addr})));
        end
    endtask

    // Mode 0, MSB first; target output is sampled before each rising sck
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        logic [7:0] shift;
        shift = tx;
        rx    = 8'h00;
        repeat (8) begin
            spi_sdi = shift[7];
            shift   = {shift[6:0], 1'b0};
            tick(SCK_HALF);
            rx      = {rx[6:0], spi_sdo};
            spi_sck = 1'b1;
            tick(SCK_HALF);
            spi_sck = 1'b0;
        end
    endtask

    task automatic end_frame_and_wait();
        int n;
        n = 0;
        tick(SCK_HALF);
        spi_cs_n = 1'b1;
        tick(2 * SCK_HALF);
        while (spi_stall !== 1'b0 && n < WAIT_LIMIT && !timed_out) begin
            tick(1);
            n++;
        end
        if (spi_stall !== 1'b0 && !timed_out) report_timeout("spi_stall_o to fall");
    endtask

    task automatic spi_write(input logic [16:0] addr, input logic [7:0] data);
        logic [7:0] rx;
        if (timed_out) return;
        spi_cs_n = 1'b0;
        tick(SCK_HALF);
        spi_byte({7'b1000000, addr[16]}, rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        spi_byte(data, rx);
        end_frame_and_wait();
        mem_model[addr] = data;
    endtask

    task automatic expect_spi_read(input logic [16:0] addr);
        logic [7:0] got;
        if (timed_out) return;
        spi_cs_n = 1'b0;
        tick(SCK_HALF);
        spi_byte({7'b1100000, addr[16]}, got);
        spi_byte(addr[15:8], got);
        spi_byte(addr[7:0], got);
        end_frame_and_wait();
        spi_cs_n = 1'b0;
        tick(SCK_HALF);
        spi_byte(8'h00, got);
        spi_byte(8'h00, got);
        end_frame_and_wait();
        if (!timed_out && got !== model_read(addr)) report_mismatch("spi read data", 32'(got),
                                                                    32'(model_read(addr)));
    endtask

    initial begin
        logic [16:0] saddr;
        logic [15:0] caddr;
        logic [16:0] spi_addrs [$];
        logic [15:0] cpu_addrs [$];
        int          n;
        void'($urandom(84));
        errors     = 0;
        timed_out  = 1'b0;
        ready_seen = 1'b0;
        reset      = 1'b1;
        cpu_addr   = '0;
        cpu_data   = '0;
        cpu_we_n   = 1'b1;
        spi_cs_n   = 1'b1;
        spi_sck    = 1'b0;
        spi_sdi    = 1'b0;

        // Reset, then idle outputs until the first CPU cycle starts
        repeat (8) begin
            tick(1);
            check_idle_outputs();
        end
        reset = 1'b0;
        n = 0;
        while (cpu_ready !== 1'b1 && n < WAIT_LIMIT) begin
            check_idle_outputs();
            tick(1);
            n++;
        end
        if (cpu_ready !== 1'b1) report_timeout("cpu_ready_o to rise");
        ready_seen = !timed_out;
        tick(2 * CYCLE_LEN);

        // SPI writes over both banks, then read back
        for (int i = 0; i < 20; i++) begin
            saddr = {i[0], 16'($urandom)};
            spi_write(saddr, 8'($urandom));
            spi_addrs.push_back(saddr);
        end
        while (spi_addrs.size() > 0) expect_spi_read(spi_addrs.pop_front());

        // CPU accesses in the lower 32K
        for (int i = 0; i < 16; i++) begin
            caddr = 16'($urandom) & 16'h7FFF;
            cpu_write(caddr, 8'($urandom));
            cpu_addrs.push_back(caddr);
        end
        while (cpu_addrs.size() > 0) expect_cpu_read(cpu_addrs.pop_front());

        // ROM images loaded over SPI survive CPU writes
        spi_write(17'h0C000, 8'h5A);
        spi_write(17'h0F000, 8'hA5);
        spi_write(17'h07000, 8'h3C);
        cpu_write(16'hC000, 8'h11);
        cpu_write(16'hF000, 8'h22);
        cpu_write(16'h7000, 8'h33);
        expect_spi_read(17'h0C000);
        expect_spi_read(17'h0F000);
        expect_spi_read(17'h07000);

        // I/O page decode, and the RAM behind it stays untouched
        spi_write(17'h0E810, 8'h66);
        cpu_write(16'hE810, 8'h77);
        expect_spi_read(17'h0E810);
        cpu_addrs = '{16'hE7FF, 16'hE800, 16'hE810, 16'hE820, 16'hE840, 16'hE830,
                      16'hE870, 16'hE84C, 16'hEC2F, 16'hEFFF, 16'hF000, 16'hC000};
        repeat (6) cpu_addrs.push_back({5'b11101, 11'($urandom)});
        while (cpu_addrs.size() > 0) expect_cpu_read(cpu_addrs.pop_front());

        // Back-to-back SPI traffic in bank 1 while the CPU works in bank 0
        fork
            for (int i = 0; i < 12; i++) begin
                caddr = 16'($urandom) & 16'h3FFF;
                cpu_write(caddr, 8'($urandom));
                expect_cpu_read(caddr);
            end
            for (int j = 0; j < 8; j++) begin
                saddr = {1'b1, 16'($urandom)};
                spi_write(saddr, 8'($urandom));
                expect_spi_read(saddr);
            end
        join

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/mock_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mock_ram (
    input  wire logic [common_pkg::RAM_ADDR_WIDTH-1:0] addr_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     data_i,
    input  wire logic                                  oe_n_i,
    input  wire logic                                  we_n_i,
    output logic [common_pkg::DATA_WIDTH-1:0]          data_o
);

    logic [common_pkg::DATA_WIDTH-1:0] mem [0:(1 << common_pkg::RAM_ADDR_WIDTH) - 1];

    // Asynchronous SRAM takes the data at the end of the write strobe
    always @(posedge we_n_i) begin
        if (!$isunknown(addr_i)) begin
            mem[addr_i] <= data_i;
        end
    end

    // Released data bus floats high
    assign data_o = oe_n_i ? 8'hFF : mem[addr_i];

endmodule

`default_nettype wire

//--- hw/pet_core.sv
`timescale 1ns/100ps
`default_nettype none

module pet_core #(
    parameter int CYCLE_LEN = 8
) (
    input  wire logic                                  sys_clock_i,
    input  wire logic                                  reset_i,
    input  wire logic [common_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  wire logic                                  cpu_we_n_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     ram_data_i,
    input  wire logic                                  spi_cs_ni,
    input  wire logic                                  spi_sck_i,
    input  wire logic                                  spi_sd_i,
    output logic                                       cpu_clock_o,
    output logic                                       cpu_be_o,
    output logic                                       cpu_ready_o,
    output logic [common_pkg::RAM_ADDR_WIDTH-1:0]      ram_addr_o,
    output logic                                       ram_oe_n_o,
    output logic                                       ram_we_n_o,
    output logic [common_pkg::DATA_WIDTH-1:0]          bus_data_o,
    output logic                                       bus_data_oe_o,
    output logic                                       bus_addr_oe_o,
    output logic                                       io_oe_n_o,
    output logic                                       pia1_cs_n_o,
    output logic                                       pia2_cs_n_o,
    output logic                                       via_cs_n_o,
    output logic                                       spi_sd_o,
    output logic                                       spi_stall_o
);

    logic [$clog2(CYCLE_LEN+1)-1:0] count;
    logic                           cycle_start;
    common_pkg::chip_sel_t          sel;
    logic                           spi_req;
    logic                           spi_ack;
    common_pkg::bus_req_t           spi_cmd;
    logic [common_pkg::DATA_WIDTH-1:0] spi_rdata;

    cycle_counter #(.CYCLE_LEN(CYCLE_LEN)) cycle_counter (
        .sys_clock_i, .reset_i, .count_o(count), .cycle_start_o(cycle_start)
    );

    address_decoder address_decoder (.cpu_addr_i, .sel_o(sel));

    bus_timing #(.CYCLE_LEN(CYCLE_LEN)) bus_timing (
        .sys_clock_i, .reset_i,
        .count_i(count), .cycle_start_i(cycle_start),
        .cpu_addr_i, .cpu_data_i, .cpu_we_n_i, .sel_i(sel),
        .spi_req_i(spi_req), .spi_cmd_i(spi_cmd), .ram_data_i,
        .cpu_clock_o, .cpu_be_o, .cpu_ready_o,
        .ram_addr_o, .ram_oe_n_o, .ram_we_n_o,
        .bus_data_o, .bus_data_oe_o, .bus_addr_oe_o,
        .io_oe_n_o, .pia1_cs_n_o, .pia2_cs_n_o, .via_cs_n_o,
        .spi_ack_o(spi_ack), .spi_rdata_o(spi_rdata)
    );

    spi_target spi_target (
        .sys_clock_i, .reset_i,
        .spi_cs_ni, .spi_sck_i, .spi_sd_i, .spi_sd_o, .spi_stall_o,
        .spi_req_o(spi_req), .spi_cmd_o(spi_cmd),
        .spi_ack_i(spi_ack), .spi_rdata_i(spi_rdata)
    );

endmodule

`default_nettype wire

//--- hw/spi_target.sv
`timescale 1ns/100ps
`default_nettype none

module spi_target (
    input  wire logic                              sys_clock_i,
    input  wire logic                              reset_i,
    input  wire logic                              spi_cs_ni,
    input  wire logic                              spi_sck_i,
    input  wire logic                              spi_sd_i,
    output logic                                   spi_sd_o,
    output logic                                   spi_stall_o,
    output logic                                   spi_req_o,
    output common_pkg::bus_req_t                   spi_cmd_o,
    input  wire logic                              spi_ack_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0] spi_rdata_i
);

    localparam logic [7:0] CMD_WRITE = 8'h80;
    localparam logic [7:0] CMD_READ  = 8'hC0;
    localparam logic [7:0] CMD_NEXT  = 8'h00;

    logic [2:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] sd_sync;
    logic       sck_rise;
    logic       frame_active;
    logic       byte_done;
    logic [2:0] bit_cnt;
    logic [1:0] byte_cnt;
    logic [6:0] rx_shift;
    logic [7:0] rx_byte;
    logic [7:0] cmd_q;
    logic [7:0] tx_shift;
    logic [7:0] rdata_q;
    logic       is_read;
    logic       is_write;
    logic [common_pkg::WB_ADDR_WIDTH-1:0] addr_q;

    assign sck_rise     = sck_sync[1] && !sck_sync[2];
    assign frame_active = !cs_sync[1];
    assign rx_byte      = {rx_shift, sd_sync[1]};
    assign byte_done    = frame_active && sck_rise && (bit_cnt == 3'd7);

    // Bit 0 of the command carries address bit 16
    assign is_read  = {cmd_q[7:1], 1'b0} == CMD_READ;
    assign is_write = {cmd_q[7:1], 1'b0} == CMD_WRITE;

    assign spi_sd_o    = tx_shift[7];
    assign spi_stall_o = spi_req_o || spi_ack_i;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            sck_sync  <= 3'b000;
            cs_sync   <= 2'b11;
            sd_sync   <= 2'b00;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            tx_shift  <= '0;
            spi_req_o <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[1:0], spi_sck_i};
            cs_sync  <= {cs_sync[0], spi_cs_ni};
            sd_sync  <= {sd_sync[0], spi_sd_i};

            if (!frame_active) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt  <= bit_cnt + 1'b1;
                tx_shift <= {tx_shift[6:0], 1'b0};
                if (bit_cnt == 3'd7 && byte_cnt != 2'd3) byte_cnt <= byte_cnt + 1'b1;
            end

            // Read data goes out in the byte after a next command
            if (byte_done && byte_cnt == 2'd0 && rx_byte == CMD_NEXT) tx_shift <= rdata_q;

            if (spi_ack_i) begin
                spi_req_o <= 1'b0;
            end else if (byte_done && ((byte_cnt == 2'd2 && is_read)
                                       || (byte_cnt == 2'd3 && is_write))) begin
                spi_req_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (frame_active && sck_rise) rx_shift <= rx_byte[6:0];
        if (byte_done) begin
            case (byte_cnt)
                2'd0: begin
                    cmd_q     <= rx_byte;
                    addr_q[16] <= rx_byte[0];
                end
                2'd1: addr_q[15:8] <= rx_byte;
                2'd2: begin
                    addr_q[7:0] <= rx_byte;
                    if (is_read) begin
                        spi_cmd_o.addr  <= {addr_q[16:8], rx_byte};
                        spi_cmd_o.wdata <= '0;
                        spi_cmd_o.we    <= 1'b0;
                    end
                end
                default: begin
                    if (is_write) begin
                        spi_cmd_o.addr  <= addr_q;
                        spi_cmd_o.wdata <= rx_byte;
                        spi_cmd_o.we    <= 1'b1;
                    end
                end
            endcase
        end
        if (spi_ack_i) rdata_q <= spi_rdata_i;
    end

endmodule

`default_nettype wire

//--- hw/bus_timing.sv
`timescale 1ns/100ps
`default_nettype none

module bus_timing #(
    parameter int CYCLE_LEN = 8
) (
    input  wire logic                                  sys_clock_i,
    input  wire logic                                  reset_i,
    input  wire logic [$clog2(CYCLE_LEN+1)-1:0]        count_i,
    input  wire logic                                  cycle_start_i,
    input  wire logic [common_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  wire logic                                  cpu_we_n_i,
    input  wire common_pkg::chip_sel_t                 sel_i,
    input  wire logic                                  spi_req_i,
    input  wire common_pkg::bus_req_t                  spi_cmd_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     ram_data_i,
    output logic                                       cpu_clock_o,
    output logic                                       cpu_be_o,
    output logic                                       cpu_ready_o,
    output logic [common_pkg::RAM_ADDR_WIDTH-1:0]      ram_addr_o,
    output logic                                       ram_oe_n_o,
    output logic                                       ram_we_n_o,
    output logic [common_pkg::DATA_WIDTH-1:0]          bus_data_o,
    output logic                                       bus_data_oe_o,
    output logic                                       bus_addr_oe_o,
    output logic                                       io_oe_n_o,
    output logic                                       pia1_cs_n_o,
    output logic                                       pia2_cs_n_o,
    output logic                                       via_cs_n_o,
    output logic                                       spi_ack_o,
    output logic [common_pkg::DATA_WIDTH-1:0]          spi_rdata_o
);

    localparam int CW   = $clog2(CYCLE_LEN + 1);
    localparam int HALF = CYCLE_LEN / 2;
    localparam logic [CW-1:0] SPI_LAST = CW'(HALF - 1);
    localparam logic [CW-1:0] CPU_LAST = CW'(CYCLE_LEN - 1);

    typedef enum logic [1:0] {idle, spi_access, spi_done, cpu_slot} state_t;

    state_t state;
    logic   ready_q;
    logic   in_cpu;
    logic   in_spi;
    logic   cpu_we_window;
    logic   spi_we_window;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            state     <= idle;
            ready_q   <= 1'b0;
            spi_ack_o <= 1'b0;
        end else begin
            if (cycle_start_i) ready_q <= 1'b1;
            // Four-phase return: ack falls once the target drops its request
            if (spi_ack_o && !spi_req_i) spi_ack_o <= 1'b0;
            case (state)
                idle, spi_done: begin
                    if (count_i == SPI_LAST && ready_q) state <= cpu_slot;
                end
                spi_access: begin
                    if (count_i == SPI_LAST) begin
                        state     <= cpu_slot;
                        spi_ack_o <= 1'b1;
                    end
                end
                default: begin
                    // Handshake still open means the next SPI slot stays unused
                    if (count_i == CPU_LAST) begin
                        if (spi_ack_o) state <= spi_done;
                        else if (spi_req_i) state <= spi_access;
                        else state <= idle;
                    end
                end
            endcase
        end
    end

    // Read data for the host is taken on the last count of the SPI slot
    always_ff @(posedge sys_clock_i) begin
        if (state == spi_access && count_i == SPI_LAST) spi_rdata_o <= ram_data_i;
    end

    assign in_cpu        = (state == cpu_slot);
    assign in_spi        = (state == spi_access);
    assign cpu_we_window = (count_i >= CW'(HALF + 1)) && (count_i <= CW'(CYCLE_LEN - 2));
    assign spi_we_window = (count_i >= CW'(1)) && (count_i <= CW'(HALF - 2));

    assign cpu_clock_o = in_cpu;
    assign cpu_be_o    = in_cpu;
    assign cpu_ready_o = ready_q | cycle_start_i;

    assign ram_addr_o = in_spi ? spi_cmd_i.addr : {1'b0, cpu_addr_i};
    assign ram_oe_n_o = !((in_cpu && cpu_we_n_i && sel_i.ram_en) || (in_spi && !spi_cmd_i.we));
    assign ram_we_n_o = !((in_cpu && !cpu_we_n_i && sel_i.ram_en && !sel_i.rom_protect
                           && cpu_we_window) || (in_spi && spi_cmd_i.we && spi_we_window));

    assign bus_data_o    = in_spi ? spi_cmd_i.wdata : cpu_data_i;
    assign bus_data_oe_o = in_spi && spi_cmd_i.we;
    assign bus_addr_oe_o = in_spi;

    assign io_oe_n_o   = !(in_cpu && cpu_we_n_i && sel_i.io_sel);
    assign pia1_cs_n_o = !(in_cpu && sel_i.pia1);
    assign pia2_cs_n_o = !(in_cpu && sel_i.pia2);
    assign via_cs_n_o  = !(in_cpu && sel_i.via);

    ack_needs_req: assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        $rose(spi_ack_o) |-> spi_req_i
    );

endmodule

`default_nettype wire

//--- hw/address_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module address_decoder (
    input  wire logic [common_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    output common_pkg::chip_sel_t                      sel_o
);

    // Write-protected ROM windows around the I/O page
    localparam logic [common_pkg::CPU_ADDR_WIDTH-1:0] ROM_LOW_BASE  = 16'hB000;
    localparam logic [common_pkg::CPU_ADDR_WIDTH-1:0] ROM_HIGH_BASE = 16'hF000;

    logic io_page;
    logic rom_low;
    logic rom_high;

    always_comb begin
        io_page  = (cpu_addr_i & common_pkg::IO_PAGE_MASK) == common_pkg::IO_PAGE_BASE;
        rom_low  = (cpu_addr_i >= ROM_LOW_BASE) && (cpu_addr_i < common_pkg::IO_PAGE_BASE);
        rom_high = (cpu_addr_i >= ROM_HIGH_BASE);

        // I/O page hides the RAM behind it
        sel_o.ram_en      = !io_page;
        sel_o.io_sel      = io_page;
        sel_o.rom_protect = rom_low || rom_high;

        // Partial decode on one address bit each, so selects may overlap
        sel_o.pia1 = io_page && ((cpu_addr_i[7:4] & common_pkg::PIA1_BASE[7:4]) != 4'h0);
        sel_o.pia2 = io_page && ((cpu_addr_i[7:4] & common_pkg::PIA2_BASE[7:4]) != 4'h0);
        sel_o.via  = io_page && ((cpu_addr_i[7:4] & common_pkg::VIA_BASE[7:4]) != 4'h0);
    end

endmodule

`default_nettype wire

//--- hw/cycle_counter.sv
`timescale 1ns/100ps
`default_nettype none

module cycle_counter #(
    parameter int CYCLE_LEN = 8
) (
    input  wire logic                           sys_clock_i,
    input  wire logic                           reset_i,
    output logic [$clog2(CYCLE_LEN+1)-1:0]      count_o,
    output logic                                cycle_start_o
);

    localparam int COUNT_WIDTH = $clog2(CYCLE_LEN + 1);
    localparam logic [COUNT_WIDTH-1:0] LAST = COUNT_WIDTH'(CYCLE_LEN - 1);

    // Pulse is high for the first count of each cycle
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            count_o       <= '0;
            cycle_start_o <= 1'b0;
        end else if (count_o == LAST) begin
            count_o       <= '0;
            cycle_start_o <= 1'b1;
        end else begin
            count_o       <= count_o + 1'b1;
            cycle_start_o <= 1'b0;
        end
    end

    // Slot decoding downstream relies on the count never passing the cycle length
    count_in_range: assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        count_o < COUNT_WIDTH'(CYCLE_LEN)
    );

endmodule

`default_nettype wire

//--- hw/common_pkg.sv
`default_nettype none

package common_pkg;

    // Bus widths
    localparam int CPU_ADDR_WIDTH = 16;
    localparam int RAM_ADDR_WIDTH = 17;
    localparam int WB_ADDR_WIDTH  = RAM_ADDR_WIDTH;
    localparam int DATA_WIDTH     = 8;

    // 2 KiB I/O page at E800-EFFF
    localparam logic [CPU_ADDR_WIDTH-1:0] IO_PAGE_BASE = 16'hE800;
    localparam logic [CPU_ADDR_WIDTH-1:0] IO_PAGE_MASK = 16'hF800;

    // Register blocks inside the I/O page
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA1_BASE = 16'hE810;
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA2_BASE = 16'hE820;
    localparam logic [CPU_ADDR_WIDTH-1:0] VIA_BASE  = 16'hE840;

    // One SRAM access requested by the SPI host
    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    wdata;
        logic                     we;
    } bus_req_t;

    // Result of decoding a CPU address
    typedef struct packed {
        logic ram_en;
        logic rom_protect;
        logic io_sel;
        logic pia1;
        logic pia2;
        logic via;
    } chip_sel_t;

endpackage

`default_nettype wire
